/* list.f */
rtl/bank_pkg.sv
rtl/main_control.sv
rtl/key_table.sv
rtl/transfer_queue.sv
rtl/ledger.sv
rtl/bank_top.sv
verification/bank_tb.sv

/* Makefile */
# Verilator simulation of the two-player transfer block

VERILATOR ?= verilator
TOP       ?= bank_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_TEXT ?= Finished with errors
PASS_TEXT ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Simulation reported errors"; exit 1; \
	fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/bank_tb.sv */
// Testbench for the two-player transfer block
// Enters transfers through the buttons and checks every result against a model
`timescale 1ns/1ps

module bank_tb;

    localparam int                             queue_depth     = 4;
    localparam logic [bank_pkg::balance_w-1:0] initial_balance = 16'd100;
    localparam logic [15:0]                    key_seed        = 16'hACE1;
    localparam int                             clock_period    = 20;
    localparam int                             random_count    = 40;
    localparam int                             stall_cycles    = 20;
    localparam int                             wait_limit      = 400;
    // Cycle budget for the watchdog
    localparam int startup_cycles  = 60;
    localparam int transfer_cycles = 60;
    localparam int transfer_total  = 4 + queue_depth + 2 + random_count;
    localparam int run_cycles      = startup_cycles + stall_cycles
                                     + transfer_total * transfer_cycles;

    logic                           clock;
    logic                           global_reset;
    logic                           start_signal;
    logic                           load_signal;
    logic [bank_pkg::amount_w-1:0]  data_in;
    logic                           result_ready;
    bank_pkg::transfer_res_t        result;
    logic                           result_valid;
    logic [bank_pkg::balance_w-1:0] balance0;
    logic [bank_pkg::balance_w-1:0] balance1;
    logic                           busy;

    bank_pkg::transfer_req_t        pending [$]; // Transfers whose result is outstanding
    logic [bank_pkg::balance_w-1:0] model_b0;
    logic [bank_pkg::balance_w-1:0] model_b1;
    logic [bank_pkg::key_w-1:0]     exp_key0;
    logic [bank_pkg::key_w-1:0]     exp_key1;
    integer                         seed;
    integer                         gap_seed;
    logic                           random_ready;
    int                             error_count;
    int                             tests_failed;
    int                             test_errors_at_start;
    int                             results_seen;
    int                             entered_count;
    int                             accepted_count = 0;

    bank_top #(
        .queue_depth     (queue_depth),
        .initial_balance (initial_balance),
        .key_seed        (key_seed)
    ) uut (
        .clock        (clock),
        .global_reset (global_reset),
        .start_signal (start_signal),
        .load_signal  (load_signal),
        .data_in      (data_in),
        .result_ready (result_ready),
        .result       (result),
        .result_valid (result_valid),
        .balance0     (balance0),
        .balance1     (balance1),
        .busy         (busy)
    );

    initial clock = 1'b0;
    always #(clock_period / 2) clock = ~clock;

    // Fibonacci LFSR with taps 16 14 13 11 and the new bit entering at bit 0
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] expected_keys(input logic [15:0] start);
        logic [15:0] s1;
        logic [15:0] s2;
        logic [7:0]  k0;
        logic [7:0]  k1;
        s1 = lfsr_step(start);
        s2 = lfsr_step(s1);
        k0 = s1[7:0];
        k1 = s2[7:0];
        if (k1 == k0) begin
            k1[0] = ~k1[0];
        end
        return {k0, k1};
    endfunction

    // Ledger rules applied to the model balances
    function automatic bank_pkg::transfer_res_t apply_rules(
        input bank_pkg::transfer_req_t        r,
        input logic [bank_pkg::balance_w-1:0] b0,
        input logic [bank_pkg::balance_w-1:0] b1
    );
        bank_pkg::transfer_res_t        res;
        logic [bank_pkg::balance_w-1:0] amt;
        amt          = {8'd0, r.amount};
        res.payer    = 1'b0;
        res.amount   = r.amount;
        res.status   = bank_pkg::ok;
        res.balance0 = b0;
        res.balance1 = b1;
        if (r.key == exp_key0) begin
            res.payer = 1'b0;
        end else if (r.key == exp_key1) begin
            res.payer = 1'b1;
        end else begin
            res.status = bank_pkg::bad_key;
        end
        if (res.status == bank_pkg::ok && amt > (res.payer ? b1 : b0)) begin
            res.status = bank_pkg::low_funds;
        end
        if (res.status == bank_pkg::ok) begin
            res.balance0 = res.payer ? b0 + amt : b0 - amt;
            res.balance1 = res.payer ? b1 - amt : b1 + amt;
        end
        return res;
    endfunction

    function automatic logic [7:0] unused_key();
        logic [7:0] k;
        k = 8'h00;
        while (k == exp_key0 || k == exp_key1) begin
            k = k + 8'd1;
        end
        return k;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_balances();
        check("balance0", balance0, model_b0);
        check("balance1", balance1, model_b1);
    endtask

    task automatic press_start();
        @(posedge clock);
        start_signal <= 1'b1;
        repeat (2) @(posedge clock);
        start_signal <= 1'b0;
        @(posedge clock);
    endtask

    task automatic press_load();
        @(posedge clock);
        load_signal <= 1'b1;
        repeat (2) @(posedge clock);
        load_signal <= 1'b0;
        @(posedge clock);
    endtask

    // data_in stays put until the load button has been released
    task automatic enter_transfer(input logic [7:0] amount, input logic [7:0] key);
        bank_pkg::transfer_req_t r;
        r.amount = amount;
        r.key    = key;
        pending.push_back(r);
        entered_count++;
        @(posedge clock);
        data_in <= amount;
        press_load();
        @(posedge clock);
        data_in <= key;
        press_load();
        press_start();
    endtask

    task automatic wait_accept();
        int cycles;
        cycles = 0;
        while (accepted_count < entered_count && cycles < wait_limit) begin
            @(posedge clock);
            cycles++;
        end
        if (cycles >= wait_limit) begin
            $display("Transfer was not taken by the queue within %0d cycles", wait_limit);
            error_count++;
        end
        repeat (5) @(posedge clock); // clear_entry lasts four cycles
    endtask

    task automatic wait_results();
        int cycles;
        cycles = 0;
        while (pending.size() != 0 && cycles < wait_limit) begin
            @(posedge clock);
            cycles++;
        end
        if (pending.size() != 0) begin
            $display("%0d results never arrived", pending.size());
            error_count++;
            pending.delete();
        end
        @(posedge clock);
    endtask

    task automatic start_test();
        test_errors_at_start = error_count;
    endtask

    task automatic finish_test(input int num, input string name);
        if (error_count == test_errors_at_start) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", num, name,
                     error_count - test_errors_at_start);
            tests_failed++;
        end
    endtask

    task automatic end_run();
        $display("tests failed: %0d of 6, results checked: %0d, errors: %0d",
                 tests_failed, results_seen, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    always @(posedge clock) begin
        if (uut.entry_valid && uut.entry_ready) begin
            accepted_count <= accepted_count + 1;
        end
    end

    always @(posedge clock) begin
        if (random_ready) begin
            result_ready <= ({$random(gap_seed)} % 4) != 0; // Ready three times in four
        end
    end

    always @(posedge clock) begin : compare_results
        bank_pkg::transfer_res_t expected;
        if (!global_reset && result_valid && result_ready) begin
            if (pending.size() == 0) begin
                $display("A result arrived with no transfer outstanding");
                error_count++;
            end else begin
                expected = apply_rules(pending.pop_front(), model_b0, model_b1);
                check("result.payer", result.payer, expected.payer);
                check("result.amount", result.amount, expected.amount);
                check("result.status", result.status, expected.status);
                check("result.balance0", result.balance0, expected.balance0);
                check("result.balance1", result.balance1, expected.balance1);
                model_b0 = expected.balance0;
                model_b1 = expected.balance1;
                results_seen++;
            end
        end
    end

    initial begin
        #(run_cycles * clock_period);
        $display("Watchdog expired after %0d cycles and stopped the run", run_cycles);
        error_count++;
        end_run();
    end

    initial begin
        int         pick;
        logic [7:0] amount;
        logic [7:0] key;
        seed                 = 32'h6732;
        gap_seed             = seed ^ 32'h1f3d;
        global_reset         = 1'b1;
        start_signal         = 1'b0;
        load_signal          = 1'b0;
        data_in              = '0;
        result_ready         = 1'b1;
        random_ready         = 1'b0;
        error_count          = 0;
        tests_failed         = 0;
        test_errors_at_start = 0;
        results_seen         = 0;
        entered_count        = 0;
        {exp_key0, exp_key1} = expected_keys(key_seed);
        model_b0             = initial_balance;
        model_b1             = initial_balance;
        repeat (2) @(posedge clock);
        global_reset <= 1'b0;

        start_test();
        press_start();
        for (int c = 0; c < startup_cycles && busy; c++) begin
            @(posedge clock);
        end
        if (busy) begin
            $display("Start-up never finished, busy stayed high");
            error_count++;
        end
        check("balance0", balance0, initial_balance);
        check("balance1", balance1, initial_balance);
        check("key0", uut.key0, exp_key0);
        check("key1", uut.key1, exp_key1);
        finish_test(1, "start-up");

        start_test();
        enter_transfer(8'd30, exp_key0);
        wait_accept();
        enter_transfer(8'd12, exp_key1);
        wait_accept();
        wait_results();
        check_balances();
        finish_test(2, "key transfers");

        start_test();
        enter_transfer(8'd20, unused_key());
        wait_accept();
        wait_results();
        check_balances();
        finish_test(3, "bad key");

        start_test();
        enter_transfer(8'hff, exp_key0);
        wait_accept();
        wait_results();
        check_balances();
        finish_test(4, "low funds");

        start_test();
        @(posedge clock);
        result_ready <= 1'b0;
        for (int i = 0; i <= queue_depth; i++) begin
            enter_transfer(8'(i + 1), (i % 2 == 0) ? exp_key0 : exp_key1);
            wait_accept();
        end
        enter_transfer(8'd5, exp_key1);
        repeat (stall_cycles) begin
            @(posedge clock);
            check("req_valid", uut.entry_valid, 1'b1);
            check("busy", busy, 1'b0);
        end
        check("accepted count", accepted_count, entered_count - 1);
        @(posedge clock);
        result_ready <= 1'b1;
        wait_accept();
        wait_results();
        check_balances();
        finish_test(5, "back-pressure");

        start_test();
        @(posedge clock);
        random_ready <= 1'b1;
        for (int n = 0; n < random_count; n++) begin
            pick   = {$random(seed)} % 3;
            amount = 8'($random(seed) & 32'h7f);
            case (pick)
                0:       key = exp_key0;
                1:       key = exp_key1;
                default: key = 8'($random(seed));
            endcase
            enter_transfer(amount, key);
            wait_accept();
        end
        @(posedge clock);
        random_ready <= 1'b0;
        @(posedge clock);
        result_ready <= 1'b1;
        wait_results();
        check_balances();
        check("balance sum", balance0 + balance1, 2 * initial_balance);
        finish_test(6, "random transfers");

        end_run();
    end

endmodule

/* rtl/bank_top.sv */
// Top level of the two-player transfer block
// Controller feeds a request FIFO that drains into the ledger
`timescale 1ns/1ps

module bank_top #(
    parameter int                             queue_depth     = 4,
    parameter logic [bank_pkg::balance_w-1:0] initial_balance = 100,
    parameter logic [15:0]                    key_seed        = 16'hACE1
) (
    input  logic                             clock,
    input  logic                             global_reset,
    input  logic                             start_signal,
    input  logic                             load_signal,
    input  logic [bank_pkg::amount_w-1:0]    data_in,
    input  logic                             result_ready,
    output bank_pkg::transfer_res_t          result,
    output logic                             result_valid,
    output logic [bank_pkg::balance_w-1:0]   balance0,
    output logic [bank_pkg::balance_w-1:0]   balance1,
    output logic                             busy
);

    logic                       table_start;
    logic                       table_done;
    logic                       init_start;
    logic                       init_done;
    logic [bank_pkg::key_w-1:0] key0;
    logic [bank_pkg::key_w-1:0] key1;
    bank_pkg::transfer_req_t    entry_req;
    logic                       entry_valid;
    logic                       entry_ready;
    bank_pkg::transfer_req_t    queued_req;
    logic                       queued_valid;
    logic                       queued_ready;

    main_control u_control (
        .clock        (clock),
        .global_reset (global_reset),
        .start_signal (start_signal),
        .load_signal  (load_signal),
        .data_in      (data_in),
        .table_done   (table_done),
        .init_done    (init_done),
        .table_start  (table_start),
        .init_start   (init_start),
        .req          (entry_req),
        .req_valid    (entry_valid),
        .req_ready    (entry_ready),
        .busy         (busy)
    );

    key_table #(.key_seed(key_seed)) u_keys (
        .clock        (clock),
        .global_reset (global_reset),
        .table_start  (table_start),
        .table_done   (table_done),
        .key0         (key0),
        .key1         (key1)
    );

    transfer_queue #(
        .payload_t (bank_pkg::transfer_req_t),
        .depth     (queue_depth)
    ) u_queue (
        .clock        (clock),
        .global_reset (global_reset),
        .in_data      (entry_req),
        .in_valid     (entry_valid),
        .in_ready     (entry_ready),
        .out_data     (queued_req),
        .out_valid    (queued_valid),
        .out_ready    (queued_ready)
    );

    ledger #(.initial_balance(initial_balance)) u_ledger (
        .clock        (clock),
        .global_reset (global_reset),
        .init_start   (init_start),
        .init_done    (init_done),
        .req          (queued_req),
        .req_valid    (queued_valid),
        .req_ready    (queued_ready),
        .key0         (key0),
        .key1         (key1),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .balance0     (balance0),
        .balance1     (balance1)
    );

endmodule

/* rtl/ledger.sv */
// Holds both balances, applies queued transfers in order and reports each outcome
`timescale 1ns/1ps

module ledger #(
    parameter logic [bank_pkg::balance_w-1:0] initial_balance = 100
) (
    input  logic                             clock,
    input  logic                             global_reset,
    input  logic                             init_start,
    output logic                             init_done,
    input  bank_pkg::transfer_req_t          req,
    input  logic                             req_valid,
    output logic                             req_ready,
    input  logic [bank_pkg::key_w-1:0]       key0,
    input  logic [bank_pkg::key_w-1:0]       key1,
    output bank_pkg::transfer_res_t          result,
    output logic                             result_valid,
    input  logic                             result_ready,
    output logic [bank_pkg::balance_w-1:0]   balance0,
    output logic [bank_pkg::balance_w-1:0]   balance1
);

    logic [bank_pkg::balance_w-1:0] bal [2];
    logic                           init_phase;
    logic                           accept;
    logic                           payer;
    logic                           payee;
    bank_pkg::reject_t              status;
    logic [bank_pkg::balance_w-1:0] amount_ext;
    logic [bank_pkg::balance_w:0]   sum;

    assign req_ready  = init_done && !result_valid;
    assign accept     = req_valid && req_ready;
    assign amount_ext = {{(bank_pkg::balance_w - bank_pkg::amount_w){1'b0}}, req.amount};
    assign payee      = ~payer;

    // Key picks the payer, a bad key defaults to player 0
    always_comb begin
        payer  = 1'b0;
        status = bank_pkg::ok;
        if (req.key == key0) begin
            payer = 1'b0;
        end else if (req.key == key1) begin
            payer = 1'b1;
        end else begin
            status = bank_pkg::bad_key;
        end
        if (status == bank_pkg::ok && amount_ext > bal[payer]) begin
            status = bank_pkg::low_funds;
        end
    end

    always_ff @(posedge clock) begin
        if (global_reset) begin
            bal[0]       <= '0;
            bal[1]       <= '0;
            init_phase   <= 1'b0;
            init_done    <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            if (init_start && !init_done) begin
                bal[init_phase] <= initial_balance; // Entry 0 first, then entry 1
                init_phase      <= 1'b1;
                if (init_phase) begin
                    init_done <= 1'b1;
                end
            end
            if (accept) begin
                result_valid <= 1'b1;
                if (status == bank_pkg::ok) begin
                    bal[payer] <= bal[payer] - amount_ext;
                    bal[payee] <= bal[payee] + amount_ext;
                end
            end else if (result_ready) begin
                result_valid <= 1'b0;
            end
        end
    end

    // Result carries balances as they will be after this transfer
    always_ff @(posedge clock) begin
        if (accept) begin
            result.payer  <= payer;
            result.amount <= req.amount;
            result.status <= status;
            if (status == bank_pkg::ok) begin
                result.balance0 <= payer ? bal[0] + amount_ext : bal[0] - amount_ext;
                result.balance1 <= payer ? bal[1] - amount_ext : bal[1] + amount_ext;
            end else begin
                result.balance0 <= bal[0];
                result.balance1 <= bal[1];
            end
        end
    end

    assign balance0 = bal[0];
    assign balance1 = bal[1];
    assign sum      = {1'b0, bal[0]} + {1'b0, bal[1]};

    sum_constant: assert property (
        @(posedge clock) disable iff (global_reset)
        init_done |=> sum == $past(sum)
    );

endmodule

/* rtl/transfer_queue.sv */
// Circular FIFO between the controller and the ledger
// Payload type is set by the instantiating module
`timescale 1ns/1ps

module transfer_queue #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     clock,
    input  logic     global_reset,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_w = $clog2(depth + 1);

    payload_t           mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [count_w-1:0] count;
    logic               push;
    logic               pop;

    assign in_ready  = (count != count_w'(depth));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clock) begin
        if (global_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Pointers meet whenever the queue is full or empty
    ptrs_meet_full: assert property (
        @(posedge clock) disable iff (global_reset)
        count == count_w'(depth) |-> wr_ptr == rd_ptr
    );

    ptrs_meet_empty: assert property (
        @(posedge clock) disable iff (global_reset)
        count == '0 |-> wr_ptr == rd_ptr
    );

endmodule

/* rtl/key_table.sv */
// Draws one secret key per player from a 16-bit Fibonacci LFSR
`timescale 1ns/1ps

module key_table #(
    parameter logic [15:0] key_seed = 16'hACE1
) (
    input  logic                         clock,
    input  logic                         global_reset,
    input  logic                         table_start,
    output logic                         table_done,
    output logic [bank_pkg::key_w-1:0]   key0,
    output logic [bank_pkg::key_w-1:0]   key1
);

    logic [15:0]                lfsr;
    logic [15:0]                lfsr_next;
    logic                       first_drawn;
    logic [bank_pkg::key_w-1:0] draw;

    // Taps 16, 14, 13, 11
    assign lfsr_next = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    assign draw      = lfsr_next[bank_pkg::key_w-1:0];

    always_ff @(posedge clock) begin
        if (global_reset) begin
            lfsr        <= key_seed;
            first_drawn <= 1'b0;
            table_done  <= 1'b0;
        end else if (table_start && !table_done) begin
            lfsr <= lfsr_next;
            if (!first_drawn) begin
                first_drawn <= 1'b1;
            end else begin
                table_done <= 1'b1; // Held until reset
            end
        end
    end

    always_ff @(posedge clock) begin
        if (table_start && !table_done) begin
            if (!first_drawn) begin
                key0 <= draw;
            end else if (draw == key0) begin
                key1 <= {draw[bank_pkg::key_w-1:1], ~draw[0]}; // Keys must differ
            end else begin
                key1 <= draw;
            end
        end
    end

    // Done follows the start strobe by two cycles
    done_timing: assert property (
        @(posedge clock) disable iff (global_reset)
        $rose(table_start) |-> ##2 $rose(table_done)
    );

endmodule

/* rtl/main_control.sv */
// Button-driven controller for the transfer block
// Sequences start-up, then gathers amount and key and submits each transfer
`timescale 1ns/1ps

module main_control (
    input  logic                          clock,
    input  logic                          global_reset,
    input  logic                          start_signal,
    input  logic                          load_signal,
    input  logic [bank_pkg::amount_w-1:0] data_in,
    input  logic                          table_done,
    input  logic                          init_done,
    output logic                          table_start,
    output logic                          init_start,
    output bank_pkg::transfer_req_t       req,
    output logic                          req_valid,
    input  logic                          req_ready,
    output logic                          busy
);

    typedef enum logic [3:0] {
        startup,
        table_init,
        ledger_init,
        clear_entry,
        idle,
        load_amount,
        wait_key,
        load_key,
        wait_start,
        submit
    } state_t;

    state_t                        state;
    state_t                        state_next;
    logic [1:0]                    clear_count;
    logic [bank_pkg::amount_w-1:0] amount_q;
    logic [bank_pkg::key_w-1:0]    key_q;
    logic                          busy_q;

    always_comb begin
        state_next = state;
        case (state)
            startup:     if (start_signal) state_next = table_init;
            table_init:  if (table_done) state_next = ledger_init;
            ledger_init: if (init_done) state_next = clear_entry;
            clear_entry: if (clear_count == 2'd3) state_next = idle;
            idle:        if (load_signal) state_next = load_amount;
            load_amount: if (!load_signal) state_next = wait_key;
            wait_key:    if (load_signal) state_next = load_key;
            load_key:    if (!load_signal) state_next = wait_start;
            wait_start:  if (start_signal) state_next = submit;
            submit:      if (req_ready) state_next = clear_entry;
            default:     state_next = startup;
        endcase
    end

    always_ff @(posedge clock) begin
        if (global_reset) begin
            state <= startup;
        end else begin
            state <= state_next;
        end
    end

    // Four cycles in clear_entry, counter parks at zero elsewhere
    always_ff @(posedge clock) begin
        if (global_reset) begin
            clear_count <= 2'd0;
        end else if (state == clear_entry) begin
            clear_count <= clear_count + 2'd1;
        end else begin
            clear_count <= 2'd0;
        end
    end

    // Busy only covers the first pass through start-up
    always_ff @(posedge clock) begin
        if (global_reset) begin
            busy_q <= 1'b1;
        end else if (state == clear_entry && clear_count == 2'd3) begin
            busy_q <= 1'b0;
        end
    end

    // Values track data_in while the button is held
    always_ff @(posedge clock) begin
        case (state)
            load_amount: amount_q <= data_in;
            load_key:    key_q <= data_in;
            clear_entry: begin
                amount_q <= '0;
                key_q    <= '0;
            end
            default: ;
        endcase
    end

    assign table_start = (state == table_init);
    assign init_start  = (state == ledger_init);
    assign req_valid   = (state == submit);
    assign req.amount  = amount_q;
    assign req.key     = key_q;
    assign busy        = busy_q;

    // A stalled request must not change under the queue
    req_hold: assert property (
        @(posedge clock) disable iff (global_reset)
        req_valid && !req_ready |=> req_valid && $stable(req)
    );

endmodule

/* rtl/bank_pkg.sv */
// Shared widths, request and result types for the two-player transfer block
package bank_pkg;

    localparam int amount_w  = 8;
    localparam int key_w     = 8;
    localparam int balance_w = 16;

    // Outcome of one transfer
    typedef enum logic [1:0] {
        ok        = 2'd0,
        bad_key   = 2'd1,
        low_funds = 2'd2
    } reject_t;

    // Entered by the players, amount in the upper byte
    typedef struct packed {
        logic [amount_w-1:0] amount;
        logic [key_w-1:0]    key;
    } transfer_req_t;

    typedef struct packed {
        logic                 payer;    // 0 when player 0 pays or the key was bad
        logic [amount_w-1:0]  amount;
        reject_t              status;
        logic [balance_w-1:0] balance0; // Balances after the transfer
        logic [balance_w-1:0] balance1;
    } transfer_res_t;

endpackage
